//--- rtl/capture_pkg.sv
package capture_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // One CCIR656 word, and one Y, Cr or Cb sample
  localparam int VID_W = 10;
  localparam int X_W = 10;
  localparam int Y_W = 9;
  localparam int NUM_COLORS = 4;

  ////////////////////////////////////////////////////////////
  // Colour boxes
  ////////////////////////////////////////////////////////////

  typedef logic [1:0] color_code_t;

  // Codes seen by the object recognition stage
  localparam color_code_t COLOR_ORANGE = 2'd0;
  localparam color_code_t COLOR_PINK = 2'd1;
  localparam color_code_t COLOR_BLUE = 2'd2;
  localparam color_code_t COLOR_GREEN = 2'd3;

  // Inclusive bounds on each component
  typedef struct packed {
    logic [VID_W-1:0] y_lo;
    logic [VID_W-1:0] y_hi;
    logic [VID_W-1:0] cr_lo;
    logic [VID_W-1:0] cr_hi;
    logic [VID_W-1:0] cb_lo;
    logic [VID_W-1:0] cb_hi;
  } box_limits_t;

  // Priority order, index 0 wins
  localparam box_limits_t BOX_LIMITS [NUM_COLORS] = '{
    '{y_lo: 10'd300, y_hi: 10'd1023, cr_lo: 10'd600, cr_hi: 10'd1023,
      cb_lo: 10'd0, cb_hi: 10'd450},
    '{y_lo: 10'd200, y_hi: 10'd600, cr_lo: 10'd300, cr_hi: 10'd480,
      cb_lo: 10'd300, cb_hi: 10'd480},
    '{y_lo: 10'd400, y_hi: 10'd1023, cr_lo: 10'd560, cr_hi: 10'd1023,
      cb_lo: 10'd560, cb_hi: 10'd1023},
    '{y_lo: 10'd150, y_hi: 10'd1023, cr_lo: 10'd0, cr_hi: 10'd440,
      cb_lo: 10'd600, cb_hi: 10'd1023}
  };

  localparam color_code_t BOX_CODE [NUM_COLORS] = '{
    COLOR_ORANGE, COLOR_GREEN, COLOR_PINK, COLOR_BLUE
  };

  // 8/5/5 display pixel
  typedef struct packed {
    logic [7:0] red;
    logic [4:0] green;
    logic [4:0] blue;
  } disp_pixel_t;

  // Marker painted over a recognised pixel, same order as BOX_LIMITS
  localparam disp_pixel_t MARKER_PIXEL [NUM_COLORS] = '{
    '{red: 8'hFF, green: 5'h1F, blue: 5'h00},
    '{red: 8'hFF, green: 5'h18, blue: 5'h00},
    '{red: 8'hFF, green: 5'h1F, blue: 5'h1F},
    '{red: 8'hFF, green: 5'h00, blue: 5'h1F}
  };

  ////////////////////////////////////////////////////////////
  // CCIR656 word
  ////////////////////////////////////////////////////////////

  // Same 10 bits seen as a sample or as the XY timing code
  typedef union packed {
    logic [VID_W-1:0] sample;
    struct packed {
      logic       marker;
      logic       f;
      logic       v;
      logic       h;
      logic [5:0] prot;
    } timing;
  } ccir_word_u;

  localparam logic [VID_W-1:0] PREAMBLE_FF = 10'h3FF;
  localparam logic [VID_W-1:0] PREAMBLE_00 = 10'h000;

endpackage

//--- rtl/pixel_if.sv
interface pixel_if
  import capture_pkg::*;
();

  // One active pixel, valid for a single cycle
  logic             valid;
  logic [X_W-1:0]   x;
  // Row relative to the top of the active window
  logic [Y_W-1:0]   row;
  logic [VID_W-1:0] lum;
  logic [VID_W-1:0] cr;
  logic [VID_W-1:0] cb;

  // Raster tracker side
  modport source (
    output valid, x, row, lum, cr, cb
  );

  // Classifiers and priority selector
  modport sink (
    input valid, x, row, lum, cr, cb
  );

endinterface

//--- rtl/ccir656_decoder.sv
module ccir656_decoder
  import capture_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  ccir_word_u       i_video_word,
  output logic             o_sample_valid,
  output logic [VID_W-1:0] o_y,
  output logic [VID_W-1:0] o_cr,
  output logic [VID_W-1:0] o_cb,
  output logic             o_line_end,
  output logic             o_field,
  output logic             o_vblank
);

  // State names the word expected on the current cycle
  localparam logic [2:0] ST_HUNT = 3'd0;
  localparam logic [2:0] ST_PRE1 = 3'd1;
  localparam logic [2:0] ST_PRE2 = 3'd2;
  localparam logic [2:0] ST_XY = 3'd3;
  localparam logic [2:0] ST_CB = 3'd4;
  localparam logic [2:0] ST_Y0 = 3'd5;
  localparam logic [2:0] ST_CR = 3'd6;
  localparam logic [2:0] ST_Y1 = 3'd7;

  logic [2:0] state;
  logic       is_ff;
  logic       is_00;
  logic       sav_ok;
  logic       y_phase;

  assign is_ff = (i_video_word.sample == PREAMBLE_FF);
  assign is_00 = (i_video_word.sample == PREAMBLE_00);
  // Start of active video outside vertical blanking
  assign sav_ok = i_video_word.timing.marker & ~i_video_word.timing.v
                  & ~i_video_word.timing.h;
  assign y_phase = (state == ST_Y0) || (state == ST_Y1);

  ////////////////////////////////////////////////////////////
  // Framing FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= ST_HUNT;
    end
    // A 3FF restarts the preamble count, unless it is the XY word itself
    else if (is_ff && state != ST_XY)
    begin
      state <= ST_PRE1;
    end
    else
    begin
      case (state)
        ST_HUNT: state <= ST_HUNT;
        ST_PRE1: state <= is_00 ? ST_PRE2 : ST_HUNT;
        ST_PRE2: state <= is_00 ? ST_XY : ST_HUNT;
        // EAV and blanked SAV codes drop back to the hunt
        ST_XY:   state <= sav_ok ? ST_CB : ST_HUNT;
        ST_Y1:   state <= ST_CB;
        // Cb, Y0, Cr walk forward one word at a time
        default: state <= state + 3'd1;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Sample and timing outputs
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      o_sample_valid <= 1'b0;
      o_line_end <= 1'b0;
      o_cb <= '0;
      o_cr <= '0;
    end
    else
    begin
      // One strobe per Y, carrying the newest Cb and Cr
      o_sample_valid <= y_phase && !is_ff;
      o_line_end <= (state == ST_XY) && i_video_word.timing.marker
                    && i_video_word.timing.h;
      if (state == ST_CB && !is_ff)
      begin
        o_cb <= i_video_word.sample;
      end
      if (state == ST_CR && !is_ff)
      begin
        o_cr <= i_video_word.sample;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (y_phase)
    begin
      o_y <= i_video_word.sample;
    end
    // F and V are only looked at together with o_line_end
    if (state == ST_XY)
    begin
      o_field <= i_video_word.timing.f;
      o_vblank <= i_video_word.timing.v;
    end
  end

endmodule

//--- rtl/raster_tracker.sv
module raster_tracker
  import capture_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int V_FIRST = 25,
  parameter int V_LINES = 480
)
(
  input  logic             clk,
  input  logic             reset,
  input  logic             i_sample_valid,
  input  logic [VID_W-1:0] i_y,
  input  logic [VID_W-1:0] i_cr,
  input  logic [VID_W-1:0] i_cb,
  input  logic             i_line_end,
  input  logic             i_field,
  input  logic             i_vblank,
  output logic             o_frame_start,
  pixel_if.source          o_pix
);

  // Window edges in counter width, row needs one bit more than Y_W
  localparam logic [Y_W:0] ROW_FIRST = (Y_W + 1)'(V_FIRST);
  localparam logic [Y_W:0] ROW_END = (Y_W + 1)'(V_FIRST + V_LINES);
  localparam logic [X_W-1:0] COL_END = X_W'(H_ACTIVE);

  logic [X_W-1:0] col;
  logic [Y_W:0]   line;
  logic           last_field;
  logic           in_window;

  assign in_window = (line >= ROW_FIRST) && (line < ROW_END) && (col < COL_END);

  ////////////////////////////////////////////////////////////
  // Raster counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      col <= '0;
      line <= '0;
      // Starts high so a frame needs an F=0 field first
      last_field <= 1'b1;
      o_frame_start <= 1'b0;
      o_pix.valid <= 1'b0;
    end
    else
    begin
      o_frame_start <= i_line_end && i_field && !last_field;
      o_pix.valid <= i_sample_valid && in_window;
      if (i_line_end)
      begin
        col <= '0;
        last_field <= i_field;
        // Interlaced rows, each field starts on its own parity
        if (i_vblank)
        begin
          line <= {{Y_W{1'b0}}, i_field};
        end
        else
        begin
          line <= line + 2'd2;
        end
      end
      else if (i_sample_valid && col != '1)
      begin
        // Holds at the top so an overlong line cannot wrap into the window
        col <= col + 1'b1;
      end
    end
  end

  // Pixel fields, qualified by o_pix.valid
  always_ff @(posedge clk)
  begin
    if (i_sample_valid)
    begin
      o_pix.x <= col;
      o_pix.row <= Y_W'(line - ROW_FIRST);
      o_pix.lum <= i_y;
      o_pix.cr <= i_cr;
      o_pix.cb <= i_cb;
    end
  end

endmodule

//--- rtl/color_box_classifier.sv
module color_box_classifier
  import capture_pkg::*;
#(
  parameter box_limits_t LIMITS = '0
)
(
  input  logic  clk,
  input  logic  reset,
  pixel_if.sink i_pix,
  output logic  o_hit
);

  logic y_in;
  logic cr_in;
  logic cb_in;

  // Per-component range test, both ends inclusive
  assign y_in = (i_pix.lum >= LIMITS.y_lo) && (i_pix.lum <= LIMITS.y_hi);
  assign cr_in = (i_pix.cr >= LIMITS.cr_lo) && (i_pix.cr <= LIMITS.cr_hi);
  assign cb_in = (i_pix.cb >= LIMITS.cb_lo) && (i_pix.cb <= LIMITS.cb_hi);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      o_hit <= 1'b0;
    end
    else
    begin
      // No hit without a pixel
      o_hit <= i_pix.valid && y_in && cr_in && cb_in;
    end
  end

endmodule

//--- rtl/color_priority_select.sv
module color_priority_select
  import capture_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  pixel_if.sink                 i_pix,
  input  logic [NUM_COLORS-1:0] i_hits,
  output logic                  o_pixel_valid,
  output logic [X_W-1:0]        o_x,
  output logic [Y_W-1:0]        o_y,
  output logic                  o_hit,
  output color_code_t           o_color,
  output disp_pixel_t           o_pixel
);

  logic             valid_q;
  logic [X_W-1:0]   x_q;
  logic [Y_W-1:0]   row_q;
  logic [VID_W-1:0] lum_q;
  logic [VID_W-1:0] cr_q;
  logic [VID_W-1:0] cb_q;
  color_code_t      sel_code;
  disp_pixel_t      sel_pixel;

  ////////////////////////////////////////////////////////////
  // Align pixel with classifier hits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= i_pix.valid;
    end
  end

  always_ff @(posedge clk)
  begin
    x_q <= i_pix.x;
    row_q <= i_pix.row;
    lum_q <= i_pix.lum;
    cr_q <= i_pix.cr;
    cb_q <= i_pix.cb;
  end

  // Lowest index hit wins, so scan from the top down
  always_comb
  begin
    // Plain video when nothing matched, top bits of each sample
    sel_code = '0;
    sel_pixel.red = lum_q[VID_W-1 -: 8];
    sel_pixel.green = cr_q[VID_W-1 -: 5];
    sel_pixel.blue = cb_q[VID_W-1 -: 5];
    for (int i = NUM_COLORS - 1; i >= 0; i--)
    begin
      if (i_hits[i])
      begin
        sel_code = BOX_CODE[i];
        sel_pixel = MARKER_PIXEL[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      o_pixel_valid <= 1'b0;
    end
    else
    begin
      o_pixel_valid <= valid_q;
    end
  end

  always_ff @(posedge clk)
  begin
    o_x <= x_q;
    o_y <= row_q;
    o_hit <= |i_hits;
    o_color <= sel_code;
    o_pixel <= sel_pixel;
  end

endmodule

//--- rtl/ntsc_color_capture.sv
module ntsc_color_capture
  import capture_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int V_FIRST = 25,
  parameter int V_LINES = 480
)
(
  input  logic                            clk,
  input  logic                            reset,
  input  logic [VID_W-1:0]                i_video_word,
  output logic                            o_pixel_valid,
  output logic [X_W-1:0]                  o_x,
  output logic [Y_W-1:0]                  o_y,
  output logic                            o_hit,
  output logic [$bits(color_code_t)-1:0]  o_color,
  output logic [$bits(disp_pixel_t)-1:0]  o_pixel,
  output logic                            o_frame_start
);

  logic                  sample_valid;
  logic [VID_W-1:0]      dec_y;
  logic [VID_W-1:0]      dec_cr;
  logic [VID_W-1:0]      dec_cb;
  logic                  line_end;
  logic                  field;
  logic                  vblank;
  logic [NUM_COLORS-1:0] hits;

  pixel_if u_pix ();

  // Stage 1, word stream to samples
  ccir656_decoder u_decoder (
    .clk            (clk),
    .reset          (reset),
    .i_video_word   (i_video_word),
    .o_sample_valid (sample_valid),
    .o_y            (dec_y),
    .o_cr           (dec_cr),
    .o_cb           (dec_cb),
    .o_line_end     (line_end),
    .o_field        (field),
    .o_vblank       (vblank)
  );

  // Stage 2, coordinates and window
  raster_tracker #(
    .H_ACTIVE (H_ACTIVE),
    .V_FIRST  (V_FIRST),
    .V_LINES  (V_LINES)
  ) u_tracker (
    .clk            (clk),
    .reset          (reset),
    .i_sample_valid (sample_valid),
    .i_y            (dec_y),
    .i_cr           (dec_cr),
    .i_cb           (dec_cb),
    .i_line_end     (line_end),
    .i_field        (field),
    .i_vblank       (vblank),
    .o_frame_start  (o_frame_start),
    .o_pix          (u_pix)
  );

  // Stage 3, one box test per colour, all in parallel
  for (genvar gi = 0; gi < NUM_COLORS; gi++)
  begin : g_box
    color_box_classifier #(
      .LIMITS (BOX_LIMITS[gi])
    ) u_box (
      .clk   (clk),
      .reset (reset),
      .i_pix (u_pix),
      .o_hit (hits[gi])
    );
  end

  // Stage 4, result word
  color_priority_select u_select (
    .clk           (clk),
    .reset         (reset),
    .i_pix         (u_pix),
    .i_hits        (hits),
    .o_pixel_valid (o_pixel_valid),
    .o_x           (o_x),
    .o_y           (o_y),
    .o_hit         (o_hit),
    .o_color       (o_color),
    .o_pixel       (o_pixel)
  );

endmodule

//--- verif/tb_ntsc_capture.sv
module tb_ntsc_capture;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int H_ACTIVE = 16;
  localparam int V_FIRST = 2;
  localparam int V_LINES = 6;
  // Cb/Y/Cr/Y groups per line give 20 pixels against a 16 wide window
  localparam int PAIRS = 10;
  localparam int BLANK_WORDS = 8;
  localparam int LINE_WORDS = 8 + BLANK_WORDS + 4 * PAIRS;
  localparam int DRAIN_WORDS = 14;
  // Reset and quiet words plus 69 lines over all tests and one drain per test
  localparam int TOTAL_WORDS = 8 + 30 + LINE_WORDS * 69 + 6 * DRAIN_WORDS;

  localparam int MODE_RAND = 0;
  localparam int MODE_BOX = 1;
  localparam int MODE_DARK = 2;

  // Y lo/hi, Cr lo/hi, Cb lo/hi in priority order orange, green, pink, blue
  localparam int LIM [4][6] = '{
    '{300, 1023, 600, 1023, 0, 450},
    '{200, 600, 300, 480, 300, 480},
    '{400, 1023, 560, 1023, 560, 1023},
    '{150, 1023, 0, 440, 600, 1023}
  };
  localparam int CODE [4] = '{0, 3, 1, 2};
  localparam int MARK [4] = '{
    (255 << 10) | (31 << 5) | 0,
    (255 << 10) | (24 << 5) | 0,
    (255 << 10) | (31 << 5) | 31,
    (255 << 10) | (0 << 5) | 31
  };

  typedef struct packed {
    int x;
    int y;
    int hit;
    int color;
    int pixel;
    int due;
  } result_t;

  logic        clk;
  logic        reset;
  logic [9:0]  video_word;
  logic        pixel_valid;
  logic [9:0]  pix_x;
  logic [8:0]  pix_y;
  logic        pix_hit;
  logic [1:0]  pix_color;
  logic [17:0] pix_rgb;
  logic        frame_start;

  logic [31:0] lfsr = 32'h4b95;
  int          cycle_count = 0;
  result_t     exp_q [$];
  // Cycle on which each expected frame start pulse is seen
  int          frame_due_q [$];

  // Model of the framing and raster state
  int model_x = 0;
  int model_row = 0;
  int cur_cb = 0;
  int cur_cr = 0;
  int last_f = 1;
  int frames_expected = 0;

  // Monitor side counters
  int frames_seen = 0;
  int pixels_seen = 0;
  int check_count = 0;
  int mon_errors = 0;
  int seq_errors = 0;

  ntsc_color_capture #(
    .H_ACTIVE (H_ACTIVE),
    .V_FIRST  (V_FIRST),
    .V_LINES  (V_LINES)
  ) u_dut (
    .clk           (clk),
    .reset         (reset),
    .i_video_word  (video_word),
    .o_pixel_valid (pixel_valid),
    .o_x           (pix_x),
    .o_y           (pix_y),
    .o_hit         (pix_hit),
    .o_color       (pix_color),
    .o_pixel       (pix_rgb),
    .o_frame_start (frame_start)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
  end

  ////////////////////////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v = v * 2 + int'(lfsr[0]);
    end
  endtask

  // Never 000 or 3FF since those are kept for timing codes
  task automatic rand_range(input int lo, input int hi, output int v);
    int r;
    take_bits(10, r);
    v = lo + r % (hi - lo + 1);
    if (v == 0)
      v = 1;
    if (v == 1023)
      v = 1022;
  endtask

  task automatic pick_pair(input int mode, output int cb, output int y0,
                           output int cr, output int y1);
    int sel;
    int b;
    take_bits(2, sel);
    take_bits(2, b);
    if (mode == MODE_BOX && sel != 0)
    begin
      rand_range(LIM[b][4], LIM[b][5], cb);
      rand_range(LIM[b][0], LIM[b][1], y0);
      rand_range(LIM[b][2], LIM[b][3], cr);
      rand_range(LIM[b][0], LIM[b][1], y1);
    end
    else
    begin
      rand_range(0, 1023, cb);
      rand_range(0, 1023, cr);
      // Dark pixels sit below the lowest Y bound of every box
      rand_range(0, (mode == MODE_DARK) ? 149 : 1023, y0);
      rand_range(0, (mode == MODE_DARK) ? 149 : 1023, y1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stream generator and model
  ////////////////////////////////////////////////////////////

  task automatic send_word(input int w);
    @(negedge clk);
    video_word = 10'(w);
  endtask

  // Result leaves the DUT 4 cycles after its Y word
  task automatic push_expected(input int x, input int y, input int lum);
    result_t e;
    e.x = x;
    e.y = y;
    e.hit = 0;
    e.color = 0;
    e.pixel = (lum / 4) * 1024 + (cur_cr / 32) * 32 + cur_cb / 32;
    e.due = cycle_count + 4;
    // Walk up from the lowest priority so the top one is kept
    for (int b = 3; b >= 0; b--)
    begin
      if (lum >= LIM[b][0] && lum <= LIM[b][1] && cur_cr >= LIM[b][2]
          && cur_cr <= LIM[b][3] && cur_cb >= LIM[b][4] && cur_cb <= LIM[b][5])
      begin
        e.hit = 1;
        e.color = CODE[b];
        e.pixel = MARK[b];
      end
    end
    exp_q.push_back(e);
  endtask

  // Preamble plus XY word with its protection bits
  task automatic send_timing(input int f, input int v, input int h);
    int xy;
    xy = 512 + f * 256 + v * 128 + h * 64 + (v ^ h) * 32 + (f ^ h) * 16
         + (f ^ v) * 8 + (f ^ v ^ h) * 4;
    send_word(1023);
    send_word(0);
    send_word(0);
    send_word(xy);
    if (h == 1)
    begin
      // Frame start pulse leaves the DUT 2 cycles after its XY word
      if (f == 1 && last_f == 0)
      begin
        frames_expected++;
        frame_due_q.push_back(cycle_count + 2);
      end
      last_f = f;
      model_x = 0;
      // Each interlaced field restarts on its own parity
      if (v == 1)
        model_row = f;
      else
        model_row = model_row + 2;
    end
  endtask

  // Cb, Y, Cr, Y seen by the decoder while it is locked
  task automatic track_word(input int k, input int w);
    if (k == 0)
      cur_cb = w;
    else if (k == 2)
      cur_cr = w;
    else
    begin
      if (model_x < H_ACTIVE && model_row >= V_FIRST && model_row < V_FIRST + V_LINES)
        push_expected(model_x, model_row - V_FIRST, w);
      model_x++;
    end
  endtask

  task automatic send_line(input int f, input int v, input int mode, input int inject);
    int words [4];
    int pos;
    int aborted;
    send_timing(f, v, 1);
    for (int i = 0; i < BLANK_WORDS; i++)
      send_word((i % 2 == 0) ? 'h200 : 'h040);
    send_timing(f, v, 0);
    pos = -1;
    aborted = 0;
    if (inject != 0)
    begin
      take_bits(5, pos);
      pos = pos + 2;
    end
    for (int p = 0; p < PAIRS; p++)
    begin
      pick_pair(mode, words[0], words[1], words[2], words[3]);
      for (int k = 0; k < 4; k++)
      begin
        if (4 * p + k == pos)
        begin
          // A stray 3FF loses the rest of the line
          send_word(1023);
          aborted = 1;
        end
        else
        begin
          send_word(words[k]);
          if (v == 0 && aborted == 0)
            track_word(k, words[k]);
        end
      end
    end
  endtask

  // Two blanked lines before the active ones
  task automatic send_field(input int f, input int n_active, input int mode,
                            input int inject);
    send_line(f, 1, mode, 0);
    send_line(f, 1, mode, 0);
    for (int i = 0; i < n_active; i++)
      send_line(f, 0, mode, inject);
  endtask

  // Line end takes the decoder back to the hunt and the pipeline empties
  task automatic finish_test(input string name, input int errs_before);
    int errs;
    send_timing(last_f, 1, 1);
    repeat (DRAIN_WORDS - 4) send_word('h200);
    if (exp_q.size() != 0)
    begin
      $display("%s: %0d expected results never came out", name, exp_q.size());
      seq_errors++;
      exp_q.delete();
    end
    if (frames_seen != frames_expected)
    begin
      $display("%s: saw %0d frame start pulses, model expects %0d", name, frames_seen,
               frames_expected);
      seq_errors++;
      frame_due_q.delete();
    end
    errs = mon_errors + seq_errors - errs_before;
    $display("Test %s: %s, %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input int got, input int want);
    check_count++;
    if (got != want)
    begin
      $display("ERROR %0t %s got %0h expected %0h", $time, name, got, want);
      mon_errors++;
    end
  endtask

  // Registered outputs are settled at the falling edge
  initial
  begin
    result_t e;
    forever
    begin
      @(negedge clk);
      if (frame_start === 1'b1)
      begin
        frames_seen++;
        if (frame_due_q.size() == 0)
        begin
          $display("Frame start pulse at %0t without an F=0 to F=1 transition", $time);
          mon_errors++;
        end
        else
          check_value("o_frame_start cycle", cycle_count, frame_due_q.pop_front());
      end
      if (pixel_valid === 1'b1)
      begin
        pixels_seen++;
        if (exp_q.size() == 0)
        begin
          $display("Unexpected result at %0t for x %0d, y %0d, no pixel was due", $time,
                   pix_x, pix_y);
          mon_errors++;
        end
        else
        begin
          e = exp_q.pop_front();
          check_value("o_pixel_valid cycle", cycle_count, e.due);
          check_value("o_x", int'(pix_x), e.x);
          check_value("o_y", int'(pix_y), e.y);
          check_value("o_hit", int'(pix_hit), e.hit);
          check_value("o_color", int'(pix_color), e.color);
          check_value("o_pixel", int'(pix_rgb), e.pixel);
        end
      end
    end
  end

  initial
  begin
    #(TOTAL_WORDS * 40);
    $display("Watchdog expired after %0d ns, the run did not complete", TOTAL_WORDS * 40);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    int errs;
    video_word = 10'h200;
    reset = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // Nothing may come out before a start of active video
    errs = mon_errors + seq_errors;
    repeat (20) send_word('h040);
    send_line(1, 1, MODE_RAND, 0);
    repeat (10) send_word('h200);
    if (pixels_seen != 0)
    begin
      $display("Pixel results came out before any start of active video");
      seq_errors++;
    end
    finish_test("quiet_start", errs);

    errs = mon_errors + seq_errors;
    send_field(0, 5, MODE_RAND, 0);
    send_field(1, 5, MODE_RAND, 0);
    finish_test("raster_window", errs);

    errs = mon_errors + seq_errors;
    send_field(0, 5, MODE_BOX, 0);
    send_field(1, 5, MODE_BOX, 0);
    finish_test("colour_boxes", errs);

    errs = mon_errors + seq_errors;
    send_field(0, 5, MODE_DARK, 0);
    send_field(1, 5, MODE_DARK, 0);
    finish_test("no_hit", errs);

    // One stray preamble per active line
    errs = mon_errors + seq_errors;
    send_field(0, 5, MODE_BOX, 1);
    send_field(1, 5, MODE_BOX, 1);
    finish_test("mid_line_abort", errs);

    // Repeated and alternating fields of blanked lines only
    errs = mon_errors + seq_errors;
    send_field(0, 0, MODE_RAND, 0);
    send_field(0, 0, MODE_RAND, 0);
    send_field(1, 0, MODE_RAND, 0);
    send_field(1, 0, MODE_RAND, 0);
    send_field(0, 0, MODE_RAND, 0);
    send_field(1, 0, MODE_RAND, 0);
    finish_test("frame_start", errs);

    $display("Checks %0d, errors %0d, pixels %0d, frame starts %0d", check_count,
             mon_errors + seq_errors, pixels_seen, frames_seen);
    if (mon_errors + seq_errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- all.f
rtl/capture_pkg.sv
rtl/pixel_if.sv
rtl/ccir656_decoder.sv
rtl/raster_tracker.sv
rtl/color_box_classifier.sv
rtl/color_priority_select.sv
rtl/ntsc_color_capture.sv
verif/tb_ntsc_capture.sv

//--- run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_ntsc_capture -o sim_tb
output=$(./obj_dir/sim_tb)
echo "$output"

if grep -q "^Simulation finished: PASS$" <<< "$output"; then
  exit 0
fi
exit 1
